// File: hdl/bitpack_pkg.sv
/* shared word size, derived widths and types of the bit packer
   import into each module body and use scoped names in the port lists */

`default_nettype none

package bitpack_pkg;

  // word size and the widths derived from it
  localparam int DATA_W = 21;
  localparam int WIDTH_W = $clog2(DATA_W + 1);
  localparam int BUF_W = 2 * DATA_W;
  localparam int LEVEL_W = $clog2(BUF_W + 1);

  // word FIFO sizing
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [WIDTH_W-1:0] width_t;
  typedef logic [LEVEL_W-1:0] level_t;

  // static configuration, only changed under reset
  typedef struct packed {
    width_t width;
    logic   wrap;
  } pack_cfg_t;

  // packer control steps
  typedef enum logic [1:0] {
    CALC_WIDTH,
    WAIT_DATA,
    PUSH_DATA,
    WAIT_POP
  } pack_state_e;

endpackage

`default_nettype wire

// File: hdl/word_fifo.sv
/* small first-word-fall-through word FIFO
   head word is visible on data_o whenever empty_o is low */

`timescale 1ns/10ps
`default_nettype none

module word_fifo (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               write_i,
  input  bitpack_pkg::word_t data_i,
  input  logic               read_i,
  output bitpack_pkg::word_t data_o,
  output logic               full_o,
  output logic               empty_o
);
  import bitpack_pkg::*;

  word_t                 mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  wr_en;
  logic                  rd_en;

  // illegal accesses are dropped here
  assign wr_en = write_i & ~full_o;
  assign rd_en = read_i & ~empty_o;

  assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        if (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (rd_en) begin
        if (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // occupancy only moves when one side acts alone
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/bit_fifo.sv
/* variable-width bit FIFO of two words, pushing and popping 1 to DATA_W bits
   oldest bit sits at the top of the buffer; a pop returns it at position w-1 */

`timescale 1ns/10ps
`default_nettype none

module bit_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                write_i,
  input  bitpack_pkg::width_t wwidth_i,
  input  bitpack_pkg::word_t  wdata_i,
  output bitpack_pkg::level_t wlevel_o,
  input  logic                read_i,
  input  bitpack_pkg::width_t rwidth_i,
  output bitpack_pkg::word_t  rdata_o,
  output bitpack_pkg::level_t rlevel_o
);
  import bitpack_pkg::*;

  // left-aligned storage, bits below the fill level are kept at zero
  logic [BUF_W-1:0] buf_q;
  logic [BUF_W-1:0] buf_d;
  logic [BUF_W-1:0] kept;
  logic [BUF_W-1:0] pushed;
  level_t           level_q;
  level_t           level_d;
  level_t           level_kept;
  word_t            chunk;

  assign rlevel_o = level_q;
  assign wlevel_o = LEVEL_W'(BUF_W) - level_q;

  // top rwidth bits, right-aligned with zeros above
  assign rdata_o = word_t'(buf_q >> (BUF_W - rwidth_i));

  always_comb begin
    kept       = buf_q;
    level_kept = level_q;

    // pop first so a push in the same cycle lands behind what remains
    if (read_i) begin
      kept       = buf_q << rwidth_i;
      level_kept = level_q - LEVEL_W'(rwidth_i);
    end

    // only the low wwidth bits of the word are valid
    chunk = wdata_i & ~(word_t'('1) << wwidth_i);

    pushed  = '0;
    level_d = level_kept;
    if (write_i) begin
      // left-align the chunk, then slide it down past the kept bits
      pushed  = ({chunk, {DATA_W{1'b0}}} << (DATA_W - wwidth_i)) >> level_kept;
      level_d = level_kept + LEVEL_W'(wwidth_i);
    end

    buf_d = kept | pushed;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      buf_q   <= '0;
      level_q <= '0;
    end else begin
      buf_q   <= buf_d;
      level_q <= level_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/bit_packer.sv
/* packs width-bit chunks from an input word FIFO into DATA_W-bit output words
   four-step control drives a bit FIFO; wrap mode keeps only whole chunks per word */

`timescale 1ns/10ps
`default_nettype none

module bit_packer (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  bitpack_pkg::pack_cfg_t cfg_i,
  // input word FIFO side
  output logic                   read_o,
  input  logic                   rempty_i,
  input  bitpack_pkg::word_t     rdata_i,
  // output word FIFO side
  output logic                   write_o,
  input  logic                   wfull_i,
  output bitpack_pkg::word_t     wdata_o
);
  import bitpack_pkg::*;

  pack_state_e      state_q;
  pack_state_e      state_d;
  width_t           acc_q;
  width_t           acc_d;
  logic [WIDTH_W:0] acc_sum;
  width_t           pop_width;
  word_t            data_q;
  logic             push;
  logic             pop;
  level_t           wlevel;
  level_t           rlevel;

  assign write_o = pop;

  always_comb begin
    // wrap mode pops the accumulated multiple of width
    pop_width = cfg_i.wrap ? acc_q : width_t'(DATA_W);
    acc_sum   = {1'b0, acc_q} + {1'b0, cfg_i.width};

    read_o  = 1'b0;
    push    = 1'b0;
    pop     = 1'b0;
    acc_d   = acc_q;
    state_d = state_q;

    case (state_q)
      CALC_WIDTH: begin
        // one chunk per cycle until the next would overflow a word
        if (cfg_i.wrap && (acc_sum <= DATA_W)) begin
          acc_d = acc_sum[WIDTH_W-1:0];
        end else begin
          state_d = WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (!rempty_i && (wlevel >= LEVEL_W'(cfg_i.width))) begin
          read_o  = 1'b1;
          state_d = PUSH_DATA;
        end else begin
          state_d = WAIT_POP;
        end
      end
      PUSH_DATA: begin
        push    = 1'b1;
        state_d = WAIT_POP;
      end
      WAIT_POP: begin
        if ((rlevel >= LEVEL_W'(pop_width)) && !wfull_i) begin
          pop = 1'b1;
        end
        state_d = WAIT_DATA;
      end
      default: begin
        state_d = CALC_WIDTH;
      end
    endcase
  end

  // head word leaves the input FIFO on read, so hold it for the push
  always_ff @(posedge clk_i) begin
    if (read_o) begin
      data_q <= rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CALC_WIDTH;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      acc_q   <= acc_d;
    end
  end

  bit_fifo i_bit_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    // chunks in
    .write_i  (push),
    .wwidth_i (cfg_i.width),
    .wdata_i  (data_q),
    .wlevel_o (wlevel),
    // packed words out
    .read_i   (pop),
    .rwidth_i (pop_width),
    .rdata_o  (wdata_o),
    .rlevel_o (rlevel)
  );

endmodule

`default_nettype wire

// File: hdl/bitpack_top.sv
/* bit packer top level, an input word FIFO feeding the packer feeding an output FIFO
   cfg_i must stay stable between resets */

`timescale 1ns/10ps
`default_nettype none

module bitpack_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  bitpack_pkg::pack_cfg_t cfg_i,
  input  logic                   in_write_i,
  input  bitpack_pkg::word_t     in_data_i,
  output logic                   in_full_o,
  input  logic                   out_read_i,
  output bitpack_pkg::word_t     out_data_o,
  output logic                   out_empty_o
);
  import bitpack_pkg::*;

  word_t in_data;
  logic  in_empty;
  logic  pk_read;
  logic  pk_write;
  word_t pk_wdata;
  logic  out_full;

  // unpacked words from the outside
  word_fifo i_in_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .write_i (in_write_i),
    .data_i  (in_data_i),
    .read_i  (pk_read),
    .data_o  (in_data),
    .full_o  (in_full_o),
    .empty_o (in_empty)
  );

  bit_packer i_packer (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cfg_i    (cfg_i),
    .read_o   (pk_read),
    .rempty_i (in_empty),
    .rdata_i  (in_data),
    .write_o  (pk_write),
    .wfull_i  (out_full),
    .wdata_o  (pk_wdata)
  );

  // packed words to the outside
  word_fifo i_out_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .write_i (pk_write),
    .data_i  (pk_wdata),
    .read_i  (out_read_i),
    .data_o  (out_data_o),
    .full_o  (out_full),
    .empty_o (out_empty_o)
  );

endmodule

`default_nettype wire

// File: tests/bitpack_sva.sv
/* concurrent checks on the packer strobes and bit FIFO levels
   bound into every bit_packer instance at the end of this file */

`timescale 1ns/10ps
`default_nettype none

module bitpack_sva (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                read_i,
  input logic                rempty_i,
  input logic                write_i,
  input logic                wfull_i,
  input bitpack_pkg::level_t rlevel_i,
  input bitpack_pkg::width_t pop_width_i
);
  import bitpack_pkg::*;

  // failure tally, read at the end of the run
  int fail_count = 0;

  level_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rlevel_i <= level_t'(BUF_W)
  ) else begin
    fail_count++;
    $error("bit FIFO holds more than two words");
  end

  no_read_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) read_i |-> !rempty_i
  ) else begin
    fail_count++;
    $error("packer read an empty input FIFO");
  end

  no_write_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) write_i |-> !wfull_i
  ) else begin
    fail_count++;
    $error("packer wrote a full output FIFO");
  end

  // wrap accumulator must stay within one word
  pop_width_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pop_width_i <= width_t'(DATA_W)
  ) else begin
    fail_count++;
    $error("pop width larger than one word");
  end

endmodule

bind bit_packer bitpack_sva i_bitpack_sva (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .read_i      (read_o),
  .rempty_i    (rempty_i),
  .write_i     (write_o),
  .wfull_i     (wfull_i),
  .rlevel_i    (rlevel),
  .pop_width_i (pop_width)
);

`default_nettype wire

// File: tests/bitpack_tb.sv
/* testbench for the bit packer top level
   runs a table of widths and modes against a bit-queue reference model */

`timescale 1ns/10ps
`default_nettype none

module bitpack_tb;
  import bitpack_pkg::*;

  localparam int CLK_HALF = 20;
  localparam int N_ROWS   = 10;
  localparam int SETTLE   = 20;

  // chunk width, mode, input words, drain hold-off cycles, drain stall mask
  typedef struct packed {
    int         width;
    logic       wrap;
    int         words;
    int         hold;
    logic [7:0] stall;
  } row_t;

  logic      clk;
  logic      rst_n;
  pack_cfg_t cfg;
  logic      in_write;
  word_t     in_data;
  logic      in_full;
  logic      out_read;
  word_t     out_data;
  logic      out_empty;

  row_t        rows [N_ROWS];
  word_t       in_words [$];
  word_t       exp_words [$];
  logic [31:0] lcg_state;
  int          cycles;
  int          cycle_limit;
  int          errors;
  int          checks;

  bitpack_top i_bitpack_top (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .cfg_i       (cfg),
    .in_write_i  (in_write),
    .in_data_i   (in_data),
    .in_full_o   (in_full),
    .out_read_i  (out_read),
    .out_data_o  (out_data),
    .out_empty_o (out_empty)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic load_table();
    rows[0] = '{8, 1'b0, 21, 0, 8'h00};
    rows[1] = '{7, 1'b0, 12, 0, 8'h05};
    rows[2] = '{21, 1'b0, 6, 0, 8'h00};
    rows[3] = '{5, 1'b1, 16, 0, 8'h00};
    rows[4] = '{8, 1'b1, 10, 0, 8'h22};
    rows[5] = '{11, 1'b1, 6, 0, 8'h00};
    rows[6] = '{1, 1'b0, 42, 0, 8'h00};
    // long hold-off lets the whole chain back up
    rows[7] = '{21, 1'b0, 16, 80, 8'h00};
    rows[8] = '{3, 1'b0, 10, 0, 8'h30};
    rows[9] = '{13, 1'b0, 11, 0, 8'h81};
  endtask

  function automatic int timeout_cycles();
    int sum;
    sum = 0;
    foreach (rows[r]) begin
      sum += rows[r].words * 8 + 100;
    end
    return sum;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%06h expected 0x%06h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic make_stimulus(input row_t row);
    in_words.delete();
    for (int n = 0; n < row.words; n++) begin
      lcg_state = lcg_next(lcg_state);
      // upper bits stay random so the chunk mask gets exercised
      in_words.push_back(word_t'(lcg_state >> 7));
    end
  endtask

  // chunks go in msb first, words come out oldest bit on top
  task automatic build_expected(input row_t row);
    bit    bits [$];
    int    take;
    word_t w;
    exp_words.delete();
    if (row.wrap) begin
      take = (DATA_W / row.width) * row.width;
    end else begin
      take = DATA_W;
    end
    foreach (in_words[n]) begin
      for (int b = row.width - 1; b >= 0; b--) begin
        bits.push_back(in_words[n][b]);
      end
      while (bits.size() >= take) begin
        w = '0;
        for (int b = 0; b < take; b++) begin
          w = {w[DATA_W-2:0], bits.pop_front()};
        end
        exp_words.push_back(w);
      end
    end
  endtask

  task automatic apply_reset(input row_t row);
    @(negedge clk);
    rst_n     = 1'b0;
    cfg.width = width_t'(row.width);
    cfg.wrap  = row.wrap;
    in_write  = 1'b0;
    out_read  = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
  endtask

  // feed and drain side by side, one decision per falling edge
  task automatic run_row(input row_t row, output logic saw_full);
    int n_in;
    int n_out;
    int cyc;
    n_in     = 0;
    n_out    = 0;
    cyc      = 0;
    saw_full = 1'b0;
    while (n_in < in_words.size() || n_out < exp_words.size()) begin
      if (n_in < in_words.size() && !in_full) begin
        in_write = 1'b1;
        in_data  = in_words[n_in];
        n_in++;
      end else begin
        in_write = 1'b0;
      end
      // with the output held off, the chain must still be backed up here
      if (row.hold > 0 && cyc == row.hold && in_full) begin
        saw_full = 1'b1;
      end
      out_read = 1'b0;
      if (n_out < exp_words.size() && cyc >= row.hold && !row.stall[cyc[2:0]]
          && !out_empty) begin
        check_word("out_data_o", out_data, exp_words[n_out]);
        out_read = 1'b1;
        n_out++;
      end
      cyc++;
      @(negedge clk);
    end
    in_write = 1'b0;
    out_read = 1'b0;
  endtask

  initial begin
    cycles = 0;
    while (cycle_limit == 0 || cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the DUT stopped producing words", cycles);
    $display("test failed");
    $finish;
  end

  initial begin
    int   row_errors;
    int   sva_fails;
    logic saw_full;
    rst_n       = 1'b0;
    cfg         = '0;
    in_write    = 1'b0;
    in_data     = '0;
    out_read    = 1'b0;
    errors      = 0;
    checks      = 0;
    cycle_limit = 0;
    lcg_state   = 32'h46cb_6adb;
    load_table();
    cycle_limit = timeout_cycles();

    foreach (rows[r]) begin
      row_errors = errors;
      make_stimulus(rows[r]);
      build_expected(rows[r]);
      apply_reset(rows[r]);
      check_flag("out_empty_o", out_empty, 1'b1);
      check_flag("in_full_o", in_full, 1'b0);
      run_row(rows[r], saw_full);
      // leftover partial word must never show up
      repeat (SETTLE) @(negedge clk);
      check_flag("out_empty_o", out_empty, 1'b1);
      if (rows[r].hold > 0) begin
        check_flag("in_full_o seen", saw_full, 1'b1);
      end
      $display("row %0d width %0d wrap %0d words %0d packed %0d: %s",
               r, rows[r].width, rows[r].wrap, rows[r].words, exp_words.size(),
               (errors == row_errors) ? "ok" : "mismatch");
    end

    sva_fails = i_bitpack_top.i_packer.i_bitpack_sva.fail_count;
    errors += sva_fails;
    $display("checks %0d errors %0d assertion failures %0d", checks, errors, sva_fails);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bitpack.f
hdl/bitpack_pkg.sv
hdl/word_fifo.sv
hdl/bit_fifo.sv
hdl/bit_packer.sv
hdl/bitpack_top.sv
tests/bitpack_sva.sv
tests/bitpack_tb.sv

// File: Makefile
# Verilator flow for the bit packer
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= bitpack_tb
FILELIST   ?= bitpack.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= test passed
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert
RUN_ARGS   ?= +verilator+error+limit+1000

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	-./$(SIM_BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
